/* vlog.f */
verilog/pcs_tx_pkg.sv
verilog/pcs_tx_credit_fifo.sv
verilog/pcs_tx_encoder.sv
verilog/pcs_tx_scrambler.sv
verilog/pcs_tx_lane_dist.sv
verilog/pcs_tx_top.sv
test/pcs_tx_chk.sv
test/pcs_tx_tb.sv

/* Makefile */
TOP = pcs_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/pcs_tx_tb.sv */
// random source honors credits; model assumes in-order delivery and AM_PERIOD 32 for a short run
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_tb;

    import pcs_tx_pkg::*;

    localparam int FIFO_DEPTH   = 8;
    localparam int AM_PERIOD    = 32;
    localparam int N_WORDS      = 3000;
    localparam int GROUP_CYCLES = N_LANES * (AM_PERIOD + 1);
    localparam int WATCHDOG_NS  = N_WORDS * 20 * 10;

    localparam logic [7:0] TERM_TYPES [8] = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
                                              BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7};

    logic                  i_clock;
    logic                  i_rst_n;
    logic                  i_xg_valid;
    logic [NB_PAYLOAD-1:0] i_xg_data;
    logic [7:0]            i_xg_ctrl;
    wire                   o_credit;
    wire                   o_block_valid;
    wire  [NB_BLOCK-1:0]   o_block;
    wire  [1:0]            o_lane;
    wire                   o_am;

    logic [NB_BLOCK-1:0] exp_q [$];
    logic [57:0]         scr_hist;
    logic [7:0]          bip_m [N_LANES];
    logic [1:0]          lane_m;
    int                  credits;
    int                  credits_back;
    int                  words_sent;
    logic                in_pkt;
    int                  pkt_left;

    pcs_tx_top
    #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .AM_PERIOD  (AM_PERIOD)
    )
    dut0
    (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_xg_valid    (i_xg_valid),
        .i_xg_data     (i_xg_data),
        .i_xg_ctrl     (i_xg_ctrl),
        .o_credit      (o_credit),
        .o_block_valid (o_block_valid),
        .o_block       (o_block),
        .o_lane        (o_lane),
        .o_am          (o_am)
    );

    always #5 i_clock = ~i_clock;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // 64b/66b block rules applied to one XGMII word
    function automatic logic [NB_BLOCK-1:0] encode_word(input logic [63:0] data,
                                                        input logic [7:0] ctrl);
        pcs_payload_u din;
        pcs_payload_u dout;
        logic [1:0]   sh;
        logic         found;
        logic         upper_idle;
        din                = data;
        sh                 = SH_CTRL;
        found              = 1'b0;
        dout.ctl.btype     = BT_IDLE;
        dout.ctl.payload   = {8{CODE_ERROR}};
        if (ctrl == 8'h00)
        begin
            sh   = SH_DATA;
            dout = din;
        end
        else if ((ctrl == 8'hFF) && (din.bytes == {8{XG_IDLE}}))
            dout.ctl.payload = '0;
        else if ((ctrl == 8'h01) && (din.bytes[0] == XG_START))
        begin
            dout.ctl.btype   = BT_START0;
            dout.ctl.payload = din.ctl.payload;
        end
        else
        begin
            for (int k = 0; k < 8; k++)
            begin
                upper_idle = 1'b1;
                for (int j = k + 1; j < 8; j++)
                    if (din.bytes[j] != XG_IDLE)
                        upper_idle = 1'b0;
                if (!found && (ctrl == (8'hFF << k)) && (din.bytes[k] == XG_TERM) && upper_idle)
                begin
                    found            = 1'b1;
                    dout.ctl.btype   = TERM_TYPES[k];
                    dout.ctl.payload = '0;
                    for (int j = 0; j < k; j++)
                        dout.bytes[j + 1] = din.bytes[j];
                end
            end
        end
        return {dout, sh};
    endfunction

    // x^58 + x^39 + 1, payload bit 0 first, hist bit 0 is the newest output bit
    task automatic scramble_block(input logic [NB_BLOCK-1:0] blk,
                                  output logic [NB_BLOCK-1:0] res);
        logic b;
        res[1:0] = blk[1:0];
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            b           = blk[i + 2] ^ scr_hist[38] ^ scr_hist[57];
            res[i + 2]  = b;
            scr_hist    = {scr_hist[56:0], b};
        end
    endtask

    function automatic logic [7:0] fold_bytes(input logic [63:0] pay);
        logic [7:0] acc;
        acc = 8'h00;
        for (int i = 0; i < 8; i++)
            acc = acc ^ pay[8 * i +: 8];
        return acc;
    endfunction

    // packet-shaped word stream with the odd illegal word
    task automatic gen_word(output logic [63:0] d, output logic [7:0] c);
        int r;
        int k;
        r = int'($urandom_range(15, 0));
        if (in_pkt && (pkt_left > 0))
        begin
            d        = {$urandom, $urandom};
            c        = 8'h00;
            pkt_left = pkt_left - 1;
        end
        else if (in_pkt)
        begin
            k      = int'($urandom_range(7, 0));
            d      = {$urandom, $urandom};
            c      = 8'hFF << k;
            in_pkt = 1'b0;
            d[8 * k +: 8] = XG_TERM;
            for (int j = k + 1; j < 8; j++)
                d[8 * j +: 8] = XG_IDLE;
        end
        else if (r == 0)
        begin
            d = {$urandom, $urandom};
            c = 8'($urandom);
            if (c == 8'h00)
                c = 8'h80;
            if ($urandom_range(1, 0) == 1)
            begin
                k             = int'($urandom_range(7, 0));
                c[k]          = 1'b1;
                d[8 * k +: 8] = XG_ERROR;
            end
        end
        else if (r < 6)
        begin
            d = {8{XG_IDLE}};
            c = 8'hFF;
        end
        else
        begin
            d        = {$urandom, $urandom};
            d[7:0]   = XG_START;
            c        = 8'h01;
            in_pkt   = 1'b1;
            pkt_left = int'($urandom_range(6, 1));
        end
    endtask

    task automatic check_marker();
        pcs_payload_u e;
        e.bytes[0] = AM_TABLE[o_lane][0];
        e.bytes[1] = AM_TABLE[o_lane][1];
        e.bytes[2] = AM_TABLE[o_lane][2];
        e.bytes[3] = bip_m[o_lane];
        e.bytes[4] = ~AM_TABLE[o_lane][0];
        e.bytes[5] = ~AM_TABLE[o_lane][1];
        e.bytes[6] = ~AM_TABLE[o_lane][2];
        e.bytes[7] = ~bip_m[o_lane];
        assert (o_block == {e, SH_CTRL})
        else
            fail_now($sformatf("[ERROR] o_block (marker): got %h, expected %h",
                               o_block, {e, SH_CTRL}));
        bip_m[o_lane] = 8'h00;
    endtask

    task automatic check_data();
        logic [NB_BLOCK-1:0] exp;
        assert (exp_q.size() > 0)
        else
            fail_now("a data block came out with no block left in the model queue");
        exp = exp_q.pop_front();
        assert (o_block == exp)
        else
            fail_now($sformatf("[ERROR] o_block: got %h, expected %h", o_block, exp));
        assert (o_lane == lane_m)
        else
            fail_now($sformatf("[ERROR] o_lane: got %h, expected %h", o_lane, lane_m));
        bip_m[lane_m] = bip_m[lane_m] ^ fold_bytes(exp[NB_BLOCK-1:2]);
        lane_m        = lane_m + 2'd1;
    endtask

    // source and drain
    initial
    begin
        logic [63:0]         d;
        logic [7:0]          c;
        logic [NB_BLOCK-1:0] blk;
        i_clock      = 1'b0;
        i_rst_n      = 1'b0;
        i_xg_valid   = 1'b0;
        i_xg_data    = '0;
        i_xg_ctrl    = '0;
        scr_hist     = '0;
        lane_m       = 2'd0;
        credits      = FIFO_DEPTH;
        credits_back = 0;
        words_sent   = 0;
        in_pkt       = 1'b0;
        pkt_left     = 0;
        for (int l = 0; l < N_LANES; l++)
            bip_m[l] = 8'h00;
        void'($urandom(32'hfc0e));
        repeat (10) @(posedge i_clock);
        i_rst_n <= 1'b1;
        while (words_sent < N_WORDS)
        begin
            @(posedge i_clock);
            if (o_credit)
            begin
                credits      = credits + 1;
                credits_back = credits_back + 1;
            end
            if ((credits > 0) && ($urandom_range(3, 0) != 0))
            begin
                gen_word(d, c);
                i_xg_valid <= 1'b1;
                i_xg_data  <= d;
                i_xg_ctrl  <= c;
                credits    = credits - 1;
                words_sent = words_sent + 1;
                scramble_block(encode_word(d, c), blk);
                exp_q.push_back(blk);
            end
            else
                i_xg_valid <= 1'b0;
        end
        while (exp_q.size() != 0)
        begin
            @(posedge i_clock);
            i_xg_valid <= 1'b0;
            if (o_credit)
            begin
                credits      = credits + 1;
                credits_back = credits_back + 1;
            end
        end
        // late or stray credits still counted here
        repeat (4)
        begin
            @(posedge i_clock);
            if (o_credit)
            begin
                credits      = credits + 1;
                credits_back = credits_back + 1;
            end
        end
        assert (credits_back == words_sent)
        else
            fail_now($sformatf("[ERROR] o_credit: got %h pulses, expected %h",
                               credits_back, words_sent));
        $display("Test passed");
        $finish;
    end

    // output monitor, sampled on the falling edge
    initial
    begin
        int   cyc;
        int   next_group;
        int   am_expect;
        logic in_group;
        cyc        = 0;
        next_group = 0;
        am_expect  = 0;
        in_group   = 1'b0;
        wait (i_rst_n);
        @(posedge i_clock);
        forever
        begin
            @(negedge i_clock);
            if (cyc == next_group)
            begin
                assert (o_am)
                else
                    fail_now("marker group did not start when it was due");
                in_group   = 1'b1;
                am_expect  = 0;
                next_group = next_group + GROUP_CYCLES;
            end
            if (o_am)
            begin
                assert (in_group && o_block_valid)
                else
                    fail_now("marker seen outside its scheduled group");
                assert (o_lane == 2'(am_expect))
                else
                    fail_now($sformatf("[ERROR] o_lane (marker): got %h, expected %h",
                                       o_lane, am_expect));
                check_marker();
                am_expect = am_expect + 1;
                lane_m    = 2'd0;
                if (am_expect == N_LANES)
                    in_group = 1'b0;
            end
            else
            begin
                assert (!in_group)
                else
                    fail_now("marker group broke off before lane 3");
                if (o_block_valid)
                    check_data();
            end
            cyc = cyc + 1;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        fail_now("run timed out before all words were drained");
    end

endmodule

`default_nettype wire

/* test/pcs_tx_chk.sv */
// bound into every pcs_tx_credit_fifo instance; checks only hold after reset release
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_chk
(
    input wire i_clock,
    input wire i_rst_n,
    input wire i_push,
    input wire i_full,
    input wire i_ptr_eq,
    input wire i_pop_ok,
    input wire i_credit
);

    // source spends credits, so the FIFO never sees a push when full
    no_push_full: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_push |-> !i_full)
    else
        $error("push while FIFO full");

    credit_after_pop: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_pop_ok |=> i_credit)
    else
        $error("no credit after pop");

    // pointers meet only when the FIFO is empty or full
    no_pop_empty: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_pop_ok |-> (!i_ptr_eq || i_full))
    else
        $error("pop while FIFO empty");

endmodule

bind pcs_tx_credit_fifo pcs_tx_chk chk0
(
    .i_clock  (i_clock),
    .i_rst_n  (i_rst_n),
    .i_push   (i_push),
    .i_full   (full),
    .i_ptr_eq (rd_ptr == wr_ptr),
    .i_pop_ok (pop_ok),
    .i_credit (o_credit)
);

`default_nettype wire

/* verilog/pcs_tx_top.sv */
// source must honor credits; a popped word reaches o_block three cycles later, output never stalls
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_top
#(
    parameter int FIFO_DEPTH = 8,
    parameter int AM_PERIOD  = 16383
)
(
    input  wire                                     i_clock,
    input  wire                                     i_rst_n,
    input  wire                                     i_xg_valid,
    input  wire  [pcs_tx_pkg::NB_PAYLOAD-1:0]       i_xg_data,
    input  wire  [7:0]                              i_xg_ctrl,
    output wire                                     o_credit,
    output wire                                     o_block_valid,
    output wire  [pcs_tx_pkg::NB_BLOCK-1:0]         o_block,
    output wire  [$clog2(pcs_tx_pkg::N_LANES)-1:0]  o_lane,
    output wire                                     o_am
);

    import pcs_tx_pkg::*;

    wire                  f_valid;
    wire [NB_PAYLOAD-1:0] f_data;
    wire [7:0]            f_ctrl;
    wire                  pull;
    wire                  e_valid;
    wire [NB_BLOCK-1:0]   e_block;
    wire                  s_valid;
    wire [NB_BLOCK-1:0]   s_block;

    pcs_tx_credit_fifo
    #(
        .FIFO_DEPTH (FIFO_DEPTH)
    )
    u_fifo
    (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_push      (i_xg_valid),
        .i_push_data (i_xg_data),
        .i_push_ctrl (i_xg_ctrl),
        .i_pop       (pull),
        .o_valid     (f_valid),
        .o_data      (f_data),
        .o_ctrl      (f_ctrl),
        .o_credit    (o_credit)
    );

    pcs_tx_encoder u_encoder
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (f_valid),
        .i_data  (f_data),
        .i_ctrl  (f_ctrl),
        .o_valid (e_valid),
        .o_block (e_block)
    );

    pcs_tx_scrambler u_scrambler
    (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_valid (e_valid),
        .i_block (e_block),
        .o_valid (s_valid),
        .o_block (s_block)
    );

    pcs_tx_lane_dist
    #(
        .AM_PERIOD (AM_PERIOD)
    )
    u_lane_dist
    (
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_valid       (s_valid),
        .i_block       (s_block),
        .o_pull        (pull),
        .o_block_valid (o_block_valid),
        .o_block       (o_block),
        .o_lane        (o_lane),
        .o_am          (o_am)
    );

endmodule

`default_nettype wire

/* verilog/pcs_tx_lane_dist.sv */
// three stages sit between o_pull and o_block; no block may arrive during a marker cycle
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_lane_dist
#(
    parameter int AM_PERIOD = 16383
)
(
    input  wire                                     i_clock,
    input  wire                                     i_rst_n,
    input  wire                                     i_valid,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1:0]         i_block,
    output logic                                    o_pull,
    output logic                                    o_block_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]         o_block,
    output logic [$clog2(pcs_tx_pkg::N_LANES)-1:0]  o_lane,
    output logic                                    o_am
);

    import pcs_tx_pkg::*;

    localparam int LANE_W  = $clog2(N_LANES);
    localparam int N_PHASE = N_LANES * (AM_PERIOD + 1);
    localparam int PHASE_W = $clog2(N_PHASE);

    // phase of the output cycle three ahead, markers at phases below N_LANES
    logic [PHASE_W-1:0]  phase;
    logic                phase_am;
    // marker flag and lane for output two and one cycles ahead
    logic                am_p2;
    logic [LANE_W-1:0]   am_lane_p2;
    logic                am_p1;
    logic [LANE_W-1:0]   am_lane_p1;
    logic [LANE_W-1:0]   lane_ptr;
    logic [7:0]          bip [N_LANES];
    pcs_payload_u        in_pay;
    pcs_payload_u        am_pay;
    logic [7:0]          in_fold;
    logic [NB_BLOCK-1:0] blk_nxt;
    logic [LANE_W-1:0]   lane_nxt;

    assign phase_am = (phase < PHASE_W'(N_LANES));
    assign o_pull   = !phase_am;

    // reset state lines up lanes 0 and 1 of the first group
    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            phase      <= PHASE_W'(2);
            am_p2      <= 1'b1;
            am_lane_p2 <= LANE_W'(1);
            am_p1      <= 1'b1;
            am_lane_p1 <= LANE_W'(0);
        end
        else
        begin
            phase      <= (phase == PHASE_W'(N_PHASE - 1)) ? '0 : phase + 1'b1;
            am_p2      <= phase_am;
            am_lane_p2 <= phase[LANE_W-1:0];
            am_p1      <= am_p2;
            am_lane_p1 <= am_lane_p2;
        end
    end

    // bit-interleaved parity, byte-wise fold of the payload
    assign in_pay = i_block[NB_BLOCK-1:2];

    always_comb
    begin
        in_fold = 8'h00;
        for (int i = 0; i < 8; i++)
            in_fold = in_fold ^ in_pay.bytes[i];
    end

    always_comb
    begin
        am_pay.bytes[0] = AM_TABLE[am_lane_p1][0];
        am_pay.bytes[1] = AM_TABLE[am_lane_p1][1];
        am_pay.bytes[2] = AM_TABLE[am_lane_p1][2];
        am_pay.bytes[3] = bip[am_lane_p1];
        am_pay.bytes[4] = ~AM_TABLE[am_lane_p1][0];
        am_pay.bytes[5] = ~AM_TABLE[am_lane_p1][1];
        am_pay.bytes[6] = ~AM_TABLE[am_lane_p1][2];
        am_pay.bytes[7] = ~bip[am_lane_p1];
    end

    assign blk_nxt  = am_p1 ? {am_pay, SH_CTRL} : i_block;
    assign lane_nxt = am_p1 ? am_lane_p1 : lane_ptr;

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            o_block_valid <= 1'b0;
            o_am          <= 1'b0;
            lane_ptr      <= '0;
            for (int l = 0; l < N_LANES; l++)
                bip[l] <= 8'h00;
        end
        else
        begin
            o_block_valid <= am_p1 || i_valid;
            o_am          <= am_p1;
            if (am_p1)
            begin
                // round-robin restarts after the group
                lane_ptr        <= '0;
                bip[am_lane_p1] <= 8'h00;
            end
            else if (i_valid)
            begin
                lane_ptr      <= lane_ptr + 1'b1;
                bip[lane_ptr] <= bip[lane_ptr] ^ in_fold;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        o_block <= blk_nxt;
        o_lane  <= lane_nxt;
    end

endmodule

`default_nettype wire

/* verilog/pcs_tx_scrambler.sv */
// scrambler state starts at zero after reset and only moves on valid blocks
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_scrambler
(
    input  wire                              i_clock,
    input  wire                              i_rst_n,
    input  wire                              i_valid,
    input  wire  [pcs_tx_pkg::NB_BLOCK-1:0]  i_block,
    output logic                             o_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]  o_block
);

    import pcs_tx_pkg::*;

    localparam int NB_STATE = 58;

    // bit 0 holds the most recent scrambled bit
    logic [NB_STATE-1:0]   state;
    logic [NB_STATE-1:0]   state_walk;
    logic [NB_PAYLOAD-1:0] scr;

    always_comb
    begin
        state_walk = state;
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            // taps 39 and 58 bits back, x^58 + x^39 + 1
            scr[i]     = i_block[i + 2] ^ state_walk[38] ^ state_walk[57];
            state_walk = {state_walk[NB_STATE-2:0], scr[i]};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            state   <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid)
                state <= state_walk;
        end
    end

    // sync header left as is
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_block <= {scr, i_block[1:0]};
    end

endmodule

`default_nettype wire

/* verilog/pcs_tx_encoder.sv */
// terminate needs data below byte k and idles above it; any other control mix becomes an error block
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_encoder
(
    input  wire                                i_clock,
    input  wire                                i_rst_n,
    input  wire                                i_valid,
    input  wire  [pcs_tx_pkg::NB_PAYLOAD-1:0]  i_data,
    input  wire  [7:0]                         i_ctrl,
    output logic                               o_valid,
    output logic [pcs_tx_pkg::NB_BLOCK-1:0]    o_block
);

    import pcs_tx_pkg::*;

    pcs_payload_u in_pay;
    pcs_payload_u out_pay;
    logic [1:0]   sh_nxt;
    logic [7:0]   idle_b;
    logic         term_hit;
    logic [2:0]   term_k;
    logic [7:0]   term_bt;

    assign in_pay = i_data;

    // per-lane control character flags
    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            idle_b[i] = i_ctrl[i] && (in_pay.bytes[i] == XG_IDLE);
        end
    end

    // find terminate position k
    always_comb
    begin
        term_hit = 1'b0;
        term_k   = 3'd0;
        for (int k = 0; k < 8; k++)
        begin
            if ((i_ctrl == (8'hFF << k)) && (in_pay.bytes[k] == XG_TERM) &&
                ((idle_b >> (k + 1)) == (8'hFF >> (k + 1))))
            begin
                term_hit = 1'b1;
                term_k   = 3'(k);
            end
        end
    end

    always_comb
    begin
        case (term_k)
            3'd0:    term_bt = BT_TERM0;
            3'd1:    term_bt = BT_TERM1;
            3'd2:    term_bt = BT_TERM2;
            3'd3:    term_bt = BT_TERM3;
            3'd4:    term_bt = BT_TERM4;
            3'd5:    term_bt = BT_TERM5;
            3'd6:    term_bt = BT_TERM6;
            default: term_bt = BT_TERM7;
        endcase
    end

    always_comb
    begin
        // error block unless one of the legal kinds matches
        sh_nxt              = SH_CTRL;
        out_pay.ctl.btype   = BT_IDLE;
        out_pay.ctl.payload = {8{CODE_ERROR}};
        if (i_ctrl == 8'h00)
        begin
            sh_nxt  = SH_DATA;
            out_pay = in_pay;
        end
        else if (idle_b == 8'hFF)
            out_pay.ctl.payload = '0;
        else if ((i_ctrl == 8'h01) && (in_pay.bytes[0] == XG_START))
        begin
            out_pay.ctl.btype   = BT_START0;
            out_pay.ctl.payload = in_pay.ctl.payload;
        end
        else if (term_hit)
        begin
            // k data bytes, zeros above
            out_pay.ctl.btype   = term_bt;
            out_pay.ctl.payload = in_pay.bytes[6:0] & ~({56{1'b1}} << (8 * term_k));
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_block <= {out_pay, sh_nxt};
    end

endmodule

`default_nettype wire

/* verilog/pcs_tx_credit_fifo.sv */
// o_valid is high only in a cycle where i_pop takes the head word; pushes while full are lost
`timescale 1ns/100ps
`default_nettype none

module pcs_tx_credit_fifo
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  wire                                i_clock,
    input  wire                                i_rst_n,
    input  wire                                i_push,
    input  wire  [pcs_tx_pkg::NB_PAYLOAD-1:0]  i_push_data,
    input  wire  [7:0]                         i_push_ctrl,
    input  wire                                i_pop,
    output logic                               o_valid,
    output logic [pcs_tx_pkg::NB_PAYLOAD-1:0]  o_data,
    output logic [7:0]                         o_ctrl,
    output logic                               o_credit
);

    import pcs_tx_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [NB_PAYLOAD-1:0] mem_data [FIFO_DEPTH];
    logic [7:0]            mem_ctrl [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  empty;
    logic                  full;
    logic                  push_ok;
    logic                  pop_ok;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign push_ok = i_push && !full;
    assign pop_ok  = i_pop && !empty;

    // head word handed out in the pop cycle
    assign o_valid = pop_ok;
    assign o_data  = mem_data[rd_ptr];
    assign o_ctrl  = mem_ctrl[rd_ptr];

    always_ff @(posedge i_clock)
    begin
        if (push_ok)
        begin
            mem_data[wr_ptr] <= i_push_data;
            mem_ctrl[wr_ptr] <= i_push_ctrl;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop_ok)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per word taken
            o_credit <= pop_ok;
        end
    end

endmodule

`default_nettype wire

/* verilog/pcs_tx_pkg.sv */
// block bit 0 goes out first (sync header in bits [1:0]); lane count fixed at four by the AM table
`default_nettype none

package pcs_tx_pkg;

    localparam int N_LANES    = 4;
    localparam int NB_BLOCK   = 66;
    localparam int NB_PAYLOAD = 64;

    localparam logic [1:0] SH_DATA = 2'b01;
    localparam logic [1:0] SH_CTRL = 2'b10;

    // 64b/66b block-type bytes
    localparam logic [7:0] BT_IDLE   = 8'h1E;
    localparam logic [7:0] BT_START0 = 8'h78;
    localparam logic [7:0] BT_TERM0  = 8'h87;
    localparam logic [7:0] BT_TERM1  = 8'h99;
    localparam logic [7:0] BT_TERM2  = 8'hAA;
    localparam logic [7:0] BT_TERM3  = 8'hB4;
    localparam logic [7:0] BT_TERM4  = 8'hCC;
    localparam logic [7:0] BT_TERM5  = 8'hD2;
    localparam logic [7:0] BT_TERM6  = 8'hE1;
    localparam logic [7:0] BT_TERM7  = 8'hFF;

    // XGMII control characters
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_START = 8'hFB;
    localparam logic [7:0] XG_TERM  = 8'hFD;
    localparam logic [7:0] XG_ERROR = 8'hFE;

    localparam logic [6:0] CODE_ERROR = 7'h1E;

    // M2 M1 M0 per lane, M0 in the low byte, lane 0 last
    localparam logic [N_LANES-1:0][2:0][7:0] AM_TABLE = {
        {8'h3D, 8'h79, 8'hA2},
        {8'h9B, 8'h65, 8'hC5},
        {8'hE6, 8'hC4, 8'hF0},
        {8'h47, 8'h76, 8'h90}
    };

    // payload as eight bytes, or as block type plus 56 bits of codes and data
    typedef union packed {
        logic [7:0][7:0] bytes;
        struct packed {
            logic [55:0] payload;
            logic [7:0]  btype;
        } ctl;
    } pcs_payload_u;

endpackage

`default_nettype wire
